// File: project.f
mips_pkg.sv
mips_data_bus_if.sv
mips_decoder.sv
mips_alu.sv
mips_register_file.sv
mips_cpu_harvard.sv
mips_cpu_data_memory.sv
mips_system.sv
mips_system_checker.sv
mips_system_tb.sv

// File: Bender.yml
package:
  name: mips_system

sources:
  - mips_pkg.sv
  - mips_data_bus_if.sv
  - mips_decoder.sv
  - mips_alu.sv
  - mips_register_file.sv
  - mips_cpu_harvard.sv
  - mips_cpu_data_memory.sv
  - mips_system.sv
  - target: simulation
    files:
      - mips_system_checker.sv
      - mips_system_tb.sv

// File: mips_system_tb.sv
module mips_system_tb;
        timeunit 1ns;
        timeprecision 1ps;
        import mips_pkg::*;

        logic        clk;
        logic        rst;
        logic        clk_enable;
        logic [31:0] instr_readdata;
        logic        active;
        logic [31:0] register_v0;
        logic [31:0] instr_address;

        logic [31:0] rom [12];
        logic [31:0] rom_index;
        logic [31:0] program_words [8][12];
        logic [31:0] expected_v0 [8];
        int          budget [8];
        int          hold [8];
        logic [31:0] lfsr_state;
        int          errors;
        int          checks;
        int          watchdog_cycles;

        mips_system DUT (
                .clk            (clk),
                .rst            (rst),
                .clk_enable     (clk_enable),
                .instr_readdata (instr_readdata),
                .active         (active),
                .register_v0    (register_v0),
                .instr_address  (instr_address)
        );

        always #50 clk = ~clk;

        // Instruction ROM, word i sits at reset_vector + 4*i.
        assign rom_index = (instr_address - reset_vector) >> 2;

        always_comb begin
                if (instr_address == 32'd0) begin
                        // Bumps v0 if a halted core still executes.
                        instr_readdata = itype(op_addiu, 2, 2, 16'd1);
                end else if (rom_index < $size(rom)) begin
                        instr_readdata = rom[rom_index];
                end else begin
                        instr_readdata = 32'd0; // NOP outside the program.
                end
        end

        function automatic logic [31:0] rtype(input logic [4:0] rs, input logic [4:0] rt,
                                              input logic [4:0] rd, input logic [4:0] shamt,
                                              input logic [5:0] funct);
                return {op_special, rs, rt, rd, shamt, funct};
        endfunction

        function automatic logic [31:0] itype(input logic [5:0] op, input logic [4:0] rs,
                                              input logic [4:0] rt, input logic [15:0] imm);
                return {op, rs, rt, imm};
        endfunction

        function automatic logic [31:0] sign_extend(input logic [15:0] half);
                return {{16{half[15]}}, half};
        endfunction

        // Taps 32, 22, 2, 1.
        function automatic logic [31:0] lfsr_step(input logic [31:0] s);
                return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
        endfunction

        function automatic logic [15:0] random_halfword();
                logic [15:0] half;
                half = 16'd0;
                for (int i = 0; i < 16; i++) begin
                        lfsr_state = lfsr_step(lfsr_state);
                        half = {half[14:0], lfsr_state[0]};
                end
                return half;
        endfunction

        task automatic load_programs();
                logic [31:0] jr_zero;
                logic [15:0] top_word;
                logic [15:0] imm_a;
                logic [15:0] imm_b;
                jr_zero  = rtype(0, 0, 0, 0, fn_jr);
                top_word = 16'((data_mem_words - 1) * 4);
                program_words[0] = '{itype(op_addiu, 0, 3, 16'd7), itype(op_addiu, 0, 4, 16'hfffd),
                        rtype(3, 4, 2, 0, fn_addu), rtype(3, 4, 5, 0, fn_subu),
                        rtype(0, 5, 5, 2, fn_sll), rtype(2, 5, 2, 0, fn_addu),
                        jr_zero, 32'd0, 32'd0, 32'd0, 32'd0, 32'd0};
                program_words[1] = '{itype(op_lui, 0, 6, 16'h1234), itype(op_ori, 6, 4, 16'h8ff0),
                        itype(op_addiu, 0, 3, 16'h00f0), itype(op_addiu, 0, 8, 16'hffff),
                        rtype(4, 3, 5, 0, fn_and), rtype(8, 3, 7, 0, fn_slt),
                        rtype(6, 5, 2, 0, fn_or), jr_zero, rtype(2, 7, 2, 0, fn_addu),
                        32'd0, 32'd0, 32'd0};
                program_words[2] = '{itype(op_lui, 0, 3, 16'hbfc0), itype(op_ori, 3, 3, 16'h0014),
                        rtype(3, 0, 4, 0, fn_jalr), itype(op_addiu, 0, 2, 16'd40),
                        itype(op_addiu, 2, 2, 16'd1000), rtype(3, 4, 5, 0, fn_subu),
                        rtype(2, 5, 2, 0, fn_addu), jr_zero, 32'd0, 32'd0, 32'd0, 32'd0};
                program_words[3] = '{itype(op_addiu, 0, 3, 16'h1234), itype(op_addiu, 0, 4, 16'h0055),
                        itype(op_sw, 0, 3, 16'd8), itype(op_sw, 0, 4, top_word),
                        itype(op_lw, 0, 5, 16'd8), itype(op_lw, 0, 6, top_word),
                        rtype(0, 5, 5, 8, fn_sll), jr_zero, rtype(5, 6, 2, 0, fn_addu),
                        32'd0, 32'd0, 32'd0};
                program_words[4] = '{itype(op_addiu, 0, 3, 16'd5), itype(op_beq, 3, 0, 16'd3),
                        itype(op_addiu, 0, 2, 16'd1), itype(op_bne, 3, 3, 16'd2),
                        itype(op_addiu, 2, 2, 16'd2), itype(op_bne, 3, 0, 16'd2),
                        itype(op_addiu, 2, 2, 16'd4), itype(op_addiu, 2, 2, 16'd8),
                        itype(op_beq, 3, 3, 16'd2), itype(op_addiu, 2, 2, 16'd16),
                        itype(op_addiu, 2, 2, 16'd32), jr_zero};
                expected_v0[0] = 32'd44;
                expected_v0[1] = 32'h123400f1;
                expected_v0[2] = 32'd44; // Delay slot 40 plus target minus link.
                expected_v0[3] = 32'h00123455;
                expected_v0[4] = 32'd23;
                budget = '{16, 16, 16, 16, 20, 10, 10, 24};
                hold   = '{0, 0, 0, 0, 0, 0, 0, 6};
                for (int p = 5; p < 7; p++) begin
                        imm_a = random_halfword();
                        imm_b = random_halfword();
                        program_words[p] = '{itype(op_addiu, 0, 2, imm_a),
                                itype(op_addiu, 0, 3, imm_b),
                                jr_zero, rtype(2, 3, 2, 0, fn_addu), 32'd0, 32'd0,
                                32'd0, 32'd0, 32'd0, 32'd0, 32'd0, 32'd0};
                        expected_v0[p] = sign_extend(imm_a) + sign_extend(imm_b);
                end
                // Same as program 0, with clk_enable held low mid-run.
                for (int i = 0; i < $size(rom); i++) begin
                        program_words[7][i] = program_words[0][i];
                end
                expected_v0[7] = expected_v0[0];
        endtask

        task automatic run_program(input int p);
                int cycles;
                @(negedge clk);
                rst = 1'b1;
                clk_enable = 1'b1;
                for (int i = 0; i < $size(rom); i++) begin
                        rom[i] = program_words[p][i];
                end
                repeat (2) @(negedge clk);
                rst = 1'b0;
                cycles = 0;
                while (active && cycles < budget[p]) begin
                        @(negedge clk);
                        cycles++;
                        clk_enable = (cycles <= 3) || (cycles > 3 + hold[p]);
                end
                if (active) begin
                        $display("program %0d did not halt", p);
                        errors++;
                end else begin
                        checks++;
                        if (register_v0 !== expected_v0[p]) begin
                                $display("[FAIL] %0t: program %0d register_v0 expected %h, got %h",
                                         $time, p, expected_v0[p], register_v0);
                                errors++;
                        end
                        repeat (4) @(negedge clk);
                        checks += 3;
                        if (register_v0 !== expected_v0[p]) begin
                                $display("[FAIL] %0t: program %0d register_v0 expected %h, got %h",
                                         $time, p, expected_v0[p], register_v0);
                                errors++;
                        end
                        if (active !== 1'b0) begin
                                $display("[FAIL] %0t: program %0d active expected 0, got %b",
                                         $time, p, active);
                                errors++;
                        end
                        if (instr_address !== 32'd0) begin
                                $display("[FAIL] %0t: program %0d instr_address expected %h, got %h",
                                         $time, p, 32'd0, instr_address);
                                errors++;
                        end
                end
        endtask

        initial begin
                int total;
                clk = 1'b0;
                rst = 1'b1;
                clk_enable = 1'b0;
                errors = 0;
                checks = 0;
                watchdog_cycles = 0;
                lfsr_state = 32'h8e4fce51;
                for (int i = 0; i < $size(rom); i++) begin
                        rom[i] = 32'd0;
                end
                load_programs();
                total = 4;
                for (int p = 0; p < $size(budget); p++) begin
                        total += budget[p] + 8; // Reset and post-halt cycles.
                end
                watchdog_cycles = total;
                for (int p = 0; p < $size(budget); p++) begin
                        run_program(p);
                end
                $display("%0d checks, %0d errors", checks, errors);
                if (errors == 0) begin
                        $display("TESTBENCH PASSED");
                end else begin
                        $display("TESTBENCH FAILED");
                end
                $finish;
        end

        initial begin
                wait (watchdog_cycles != 0);
                #(watchdog_cycles * 100);
                $display("watchdog expired before all programs finished");
                $display("TESTBENCH FAILED");
                $finish;
        end

endmodule

// File: mips_system_checker.sv
module mips_system_checker (
        input logic        clk,
        input logic        rst,
        input logic        active,
        input logic [31:0] instr_address,
        input logic        mem_write,
        input logic        mem_read
);
        timeunit 1ns;
        timeprecision 1ps;
        import mips_pkg::*;

        reset_fetch: assert property (@(posedge clk) rst |=> instr_address == reset_vector)
                else $error("instr_address is not the reset vector after reset");

        strobes_exclusive: assert property (@(posedge clk) disable iff (rst)
                !(mem_write && mem_read))
                else $error("data memory read and write strobes are high together");

        fetch_aligned: assert property (@(posedge clk) disable iff (rst)
                active |-> instr_address[1:0] == 2'b00)
                else $error("instr_address is not word aligned");

        // Halt is sticky until the next reset.
        halt_sticky: assert property (@(posedge clk) disable iff (rst)
                !active |=> !active && instr_address == 32'd0)
                else $error("core left the halted state without reset");

endmodule

bind mips_system mips_system_checker bound_checks (
        .clk           (clk),
        .rst           (rst),
        .active        (active),
        .instr_address (instr_address),
        .mem_write     (data_bus.write),
        .mem_read      (data_bus.read)
);

// File: mips_system.sv
module mips_system (
        input  logic        clk,
        input  logic        rst,
        input  logic        clk_enable,
        input  logic [31:0] instr_readdata,
        output logic        active,
        output logic [31:0] register_v0,
        output logic [31:0] instr_address
);

        mips_data_bus_if data_bus ();

        mips_cpu_harvard cpu (
                .clk            (clk),
                .rst            (rst),
                .clk_enable     (clk_enable),
                .instr_readdata (instr_readdata),
                .active         (active),
                .register_v0    (register_v0),
                .instr_address  (instr_address),
                .data           (data_bus.master)
        );

        mips_cpu_data_memory dmem (
                .clk        (clk),
                .rst        (rst),
                .clk_enable (clk_enable),
                .bus        (data_bus.slave)
        );

endmodule

// File: mips_cpu_data_memory.sv
module mips_cpu_data_memory (
        input  logic           clk,
        input  logic           rst,
        input  logic           clk_enable,
        mips_data_bus_if.slave bus
);
        import mips_pkg::*;

        logic [31:0] mem [data_mem_words];
        logic [$clog2(data_mem_words)-1:0] word_index;

        assign word_index = bus.address[$clog2(data_mem_words)+1:2]; // Word addressed.

        always_ff @(posedge clk) begin
                if (rst) begin
                        for (int i = 0; i < data_mem_words; i++) begin
                                mem[i] <= 32'b0;
                        end
                end else if (clk_enable && bus.write) begin
                        mem[word_index] <= bus.writedata;
                end
        end

        always_comb begin
                if (bus.read) begin
                        bus.readdata = mem[word_index];
                end else begin
                        bus.readdata = 32'b0;
                end
        end

endmodule

// File: mips_cpu_harvard.sv
module mips_cpu_harvard (
        input  logic           clk,
        input  logic           rst,
        input  logic           clk_enable,
        input  logic [31:0]    instr_readdata,
        output logic           active,
        output logic [31:0]    register_v0,
        output logic [31:0]    instr_address,
        mips_data_bus_if.master data
);
        import mips_pkg::*;

        instr_t      instr;
        alu_op_t     alu_op;
        logic        use_imm;
        logic        imm_zero_ext;
        logic        reg_write;
        logic        write_rd;
        logic        link;
        logic        mem_read;
        logic        mem_write;
        logic        is_branch;
        logic        branch_ne;
        logic        is_jump;
        logic        jump_reg;
        logic        is_lui;

        logic [31:0] pc;
        logic [31:0] next_pc;
        logic [31:0] pc_plus4;
        logic [31:0] redirect;
        logic [31:0] branch_target;
        logic [31:0] jump_target;
        logic        branch_taken;

        logic [31:0] rs_data;
        logic [31:0] rt_data;
        logic [31:0] imm_ext;
        logic [31:0] alu_b;
        logic [31:0] alu_result;
        logic [4:0]  wb_addr;
        logic [31:0] wb_data;

        assign instr         = instr_readdata;
        assign instr_address = pc;

        mips_decoder decoder (
                .instr        (instr),
                .alu_op       (alu_op),
                .use_imm      (use_imm),
                .imm_zero_ext (imm_zero_ext),
                .reg_write    (reg_write),
                .write_rd     (write_rd),
                .link         (link),
                .mem_read     (mem_read),
                .mem_write    (mem_write),
                .is_branch    (is_branch),
                .branch_ne    (branch_ne),
                .is_jump      (is_jump),
                .jump_reg     (jump_reg),
                .is_lui       (is_lui)
        );

        always_comb begin
                if (is_lui) begin
                        imm_ext = {instr.i.imm16, 16'b0};
                end else if (imm_zero_ext) begin
                        imm_ext = {16'b0, instr.i.imm16};
                end else begin
                        imm_ext = {{16{instr.i.imm16[15]}}, instr.i.imm16};
                end
        end

        assign alu_b = use_imm ? imm_ext : rt_data;

        mips_alu alu (
                .op     (alu_op),
                .a      (rs_data),
                .b      (alu_b),
                .shamt  (instr.r.shamt),
                .result (alu_result)
        );

        assign wb_addr = write_rd ? instr.r.rd : instr.i.rt;

        always_comb begin
                if (link) begin
                        wb_data = pc + 32'd8; // Skips the delay slot.
                end else if (mem_read) begin
                        wb_data = data.readdata;
                end else begin
                        wb_data = alu_result;
                end
        end

        mips_register_file regfile (
                .clk         (clk),
                .rst         (rst),
                .clk_enable  (clk_enable),
                .read_addr_a (instr.i.rs),
                .read_addr_b (instr.i.rt),
                .write_addr  (wb_addr),
                .write_data  (wb_data),
                .write_en    (reg_write && active),
                .read_data_a (rs_data),
                .read_data_b (rt_data),
                .v0          (register_v0)
        );

        assign pc_plus4      = pc + 32'd4;
        assign branch_target = pc_plus4 + {{14{instr.i.imm16[15]}}, instr.i.imm16, 2'b00};
        assign jump_target   = {pc_plus4[31:28], instr[25:0], 2'b00};
        assign branch_taken  = is_branch && ((rs_data == rt_data) != branch_ne);

        always_comb begin
                if (branch_taken) begin
                        redirect = branch_target;
                end else if (is_jump) begin
                        redirect = jump_reg ? rs_data : jump_target;
                end else begin
                        redirect = next_pc + 32'd4;
                end
        end

        // PC steps into the delay slot while next_pc takes the target.
        always_ff @(posedge clk) begin
                if (rst) begin
                        pc      <= reset_vector;
                        next_pc <= reset_vector + 32'd4;
                        active  <= 1'b1;
                end else if (clk_enable && active) begin
                        pc      <= next_pc;
                        next_pc <= redirect;
                        active  <= (next_pc != 32'd0); // Halt on reaching address 0.
                end
        end

        assign data.address   = alu_result;
        assign data.writedata = rt_data;
        assign data.write     = mem_write && active;
        assign data.read      = mem_read && active;

endmodule

// File: mips_register_file.sv
module mips_register_file (
        input  logic        clk,
        input  logic        rst,
        input  logic        clk_enable,
        input  logic [4:0]  read_addr_a,
        input  logic [4:0]  read_addr_b,
        input  logic [4:0]  write_addr,
        input  logic [31:0] write_data,
        input  logic        write_en,
        output logic [31:0] read_data_a,
        output logic [31:0] read_data_b,
        output logic [31:0] v0
);

        logic [31:0] regs [32];

        always_ff @(posedge clk) begin
                if (rst) begin
                        for (int i = 0; i < 32; i++) begin
                                regs[i] <= 32'b0;
                        end
                end else if (clk_enable && write_en && write_addr != 5'd0) begin
                        regs[write_addr] <= write_data;
                end
        end

        // Register zero is never written, so it reads as zero.
        assign read_data_a = regs[read_addr_a];
        assign read_data_b = regs[read_addr_b];

        assign v0 = regs[2];

endmodule

// File: mips_alu.sv
module mips_alu (
        input  mips_pkg::alu_op_t op,
        input  logic [31:0]       a,
        input  logic [31:0]       b,
        input  logic [4:0]        shamt,
        output logic [31:0]       result
);
        import mips_pkg::*;

        logic signed_less;

        assign signed_less = $signed(a) < $signed(b);

        always_comb begin
                case (op)
                alu_add: begin
                        result = a + b;
                end
                alu_sub: begin
                        result = a - b;
                end
                alu_and: begin
                        result = a & b;
                end
                alu_or: begin
                        result = a | b;
                end
                alu_sll: begin
                        result = b << shamt; // SLL shifts rt.
                end
                alu_slt: begin
                        result = {31'b0, signed_less};
                end
                alu_pass_b: begin
                        result = b;
                end
                default: begin
                        result = 32'b0;
                end
                endcase
        end

endmodule

// File: mips_decoder.sv
module mips_decoder (
        input  mips_pkg::instr_t  instr,
        output mips_pkg::alu_op_t alu_op,
        output logic              use_imm,
        output logic              imm_zero_ext,
        output logic              reg_write,
        output logic              write_rd,
        output logic              link,
        output logic              mem_read,
        output logic              mem_write,
        output logic              is_branch,
        output logic              branch_ne,
        output logic              is_jump,
        output logic              jump_reg,
        output logic              is_lui
);
        import mips_pkg::*;

        always_comb begin
                alu_op       = alu_nop;
                use_imm      = 1'b0;
                imm_zero_ext = 1'b0;
                reg_write    = 1'b0;
                write_rd     = 1'b0;
                link         = 1'b0;
                mem_read     = 1'b0;
                mem_write    = 1'b0;
                is_branch    = 1'b0;
                branch_ne    = 1'b0;
                is_jump      = 1'b0;
                jump_reg     = 1'b0;
                is_lui       = 1'b0;

                case (instr.i.opcode)
                op_special: begin
                        write_rd = 1'b1;
                        case (instr.r.funct)
                        fn_sll:  begin alu_op = alu_sll; reg_write = 1'b1; end
                        fn_addu: begin alu_op = alu_add; reg_write = 1'b1; end
                        fn_subu: begin alu_op = alu_sub; reg_write = 1'b1; end
                        fn_and:  begin alu_op = alu_and; reg_write = 1'b1; end
                        fn_or:   begin alu_op = alu_or;  reg_write = 1'b1; end
                        fn_slt:  begin alu_op = alu_slt; reg_write = 1'b1; end
                        fn_jr: begin
                                is_jump  = 1'b1;
                                jump_reg = 1'b1;
                        end
                        fn_jalr: begin
                                is_jump   = 1'b1;
                                jump_reg  = 1'b1;
                                link      = 1'b1; // Return address goes to rd.
                                reg_write = 1'b1;
                        end
                        default: write_rd = 1'b0;
                        endcase
                end
                op_addiu: begin
                        alu_op    = alu_add;
                        use_imm   = 1'b1;
                        reg_write = 1'b1;
                end
                op_lui: begin
                        alu_op    = alu_pass_b;
                        use_imm   = 1'b1;
                        is_lui    = 1'b1;
                        reg_write = 1'b1;
                end
                op_ori: begin
                        alu_op       = alu_or;
                        use_imm      = 1'b1;
                        imm_zero_ext = 1'b1;
                        reg_write    = 1'b1;
                end
                op_lw: begin
                        alu_op    = alu_add; // Base plus offset.
                        use_imm   = 1'b1;
                        mem_read  = 1'b1;
                        reg_write = 1'b1;
                end
                op_sw: begin
                        alu_op    = alu_add;
                        use_imm   = 1'b1;
                        mem_write = 1'b1;
                end
                op_beq: is_branch = 1'b1;
                op_bne: begin
                        is_branch = 1'b1;
                        branch_ne = 1'b1;
                end
                op_j: is_jump = 1'b1;
                default: ; // Unsupported opcodes act as a NOP.
                endcase
        end

endmodule

// File: mips_data_bus_if.sv
interface mips_data_bus_if;

        logic [31:0] address;
        logic [31:0] writedata;
        logic [31:0] readdata;
        logic        write;
        logic        read;

        modport master (
                output address,
                output writedata,
                output write,
                output read,
                input  readdata
        );

        modport slave (
                input  address,
                input  writedata,
                input  write,
                input  read,
                output readdata
        );

endinterface

// File: mips_pkg.sv
package mips_pkg;

        localparam logic [31:0] reset_vector = 32'hBFC00000;

        localparam int data_mem_words = 256;

        // Major opcodes.
        localparam logic [5:0] op_special = 6'h00;
        localparam logic [5:0] op_j       = 6'h02;
        localparam logic [5:0] op_beq     = 6'h04;
        localparam logic [5:0] op_bne     = 6'h05;
        localparam logic [5:0] op_addiu   = 6'h09;
        localparam logic [5:0] op_ori     = 6'h0d;
        localparam logic [5:0] op_lui     = 6'h0f;
        localparam logic [5:0] op_lw      = 6'h23;
        localparam logic [5:0] op_sw      = 6'h2b;

        // Function codes under op_special.
        localparam logic [5:0] fn_sll  = 6'h00;
        localparam logic [5:0] fn_jr   = 6'h08;
        localparam logic [5:0] fn_jalr = 6'h09;
        localparam logic [5:0] fn_addu = 6'h21;
        localparam logic [5:0] fn_subu = 6'h23;
        localparam logic [5:0] fn_and  = 6'h24;
        localparam logic [5:0] fn_or   = 6'h25;
        localparam logic [5:0] fn_slt  = 6'h2a;

        typedef enum logic [2:0] {
                alu_nop,   // Result is zero.
                alu_add,
                alu_sub,
                alu_and,
                alu_or,
                alu_sll,
                alu_slt,
                alu_pass_b
        } alu_op_t;

        typedef struct packed {
                logic [5:0] opcode;
                logic [4:0] rs;
                logic [4:0] rt;
                logic [4:0] rd;
                logic [4:0] shamt;
                logic [5:0] funct;
        } r_view_t;

        typedef struct packed {
                logic [5:0]  opcode;
                logic [4:0]  rs;
                logic [4:0]  rt;
                logic [15:0] imm16;
        } i_view_t;

        // J target is the low 26 bits of either view.
        typedef union packed {
                r_view_t r;
                i_view_t i;
        } instr_t;

endpackage
